//--- common/symbolGame_cfg.svh
`ifndef SYMBOLGAME_CFG_SVH
`define SYMBOLGAME_CFG_SVH

// Clocks per game second
`define TICK_CYCLES 8

// Phase lengths in game seconds
`define PRELIM_TICKS 3
`define GAME_SYMBOLS 10
`define ANSWER_TICKS 6

// LFSR base seed
// Upper bits set so that seed xor level is never zero
`define SYMBOL_SEED 8'hA5

// Largest count difference that still wins the round
`define LOSE_MARGIN 1

`endif

//--- common/symbolGamePkg.sv
package symbolGamePkg;

  // Round phases in the order a round walks through them
  typedef enum logic [2:0] {
    phaseIdle,
    phasePrelim,
    phasePlay,
    phaseAnswer,
    phaseReview
  } gamePhase_t;

  typedef logic [7:0] segPattern_t;  // Active low, bit 7 is dp, bit 0 is segment a
  typedef logic [1:0] symbol_t;      // Symbol 0 is the one to count
  typedef logic [6:0] count_t;       // Saturates at 99
  typedef logic [4:0] level_t;
  typedef logic [3:0] ticks_t;

  localparam segPattern_t segBlank      = 8'b1111_1111;
  localparam segPattern_t segLetterL    = 8'b1100_0111;
  localparam segPattern_t segLetterP    = 8'b1000_1100;
  localparam segPattern_t segLetterS    = 8'b1001_0010;
  localparam segPattern_t segLetterD    = 8'b1010_0001;  // Lower case d
  localparam segPattern_t segLetterO    = 8'b1100_0000;
  localparam segPattern_t segLetterE    = 8'b1000_0110;
  localparam segPattern_t segDash       = 8'b1011_1111;  // Segment g only
  localparam segPattern_t segUnderscore = 8'b1111_0111;  // Segment d only

  // Decimal digit to segments, anything above 9 blanks
  function automatic segPattern_t digitToSeg(input logic [3:0] digit);
    case (digit)
      4'd0: return 8'b1100_0000;
      4'd1: return 8'b1111_1001;
      4'd2: return 8'b1010_0100;
      4'd3: return 8'b1011_0000;
      4'd4: return 8'b1001_1001;
      4'd5: return 8'b1001_0010;
      4'd6: return 8'b1000_0010;
      4'd7: return 8'b1111_1000;
      4'd8: return 8'b1000_0000;
      4'd9: return 8'b1001_0000;
      default: return segBlank;
    endcase
  endfunction

  function automatic segPattern_t symbolToSeg(input symbol_t symbol);
    case (symbol)
      2'd0: return 8'b1001_1100;     // Upper box, the target
      2'd1: return 8'b1010_0011;     // Lower box
      2'd2: return 8'b1111_0110;     // Top and bottom bars
      default: return 8'b1100_1001;  // Two side bars
    endcase
  endfunction

endpackage

//--- source/phaseController.sv
`timescale 1ns/10ps
`include "symbolGame_cfg.svh"

module phaseController (
  input  logic                       Clk1Hz,
  input  logic                       postPeriod,
  input  logic                       start,
  input  logic                       lose,
  output symbolGamePkg::gamePhase_t  phase,
  output logic                       tick,
  output symbolGamePkg::ticks_t      countDownTime,
  output logic [1:0]                 reviewPage,
  output symbolGamePkg::level_t      level
);
  import symbolGamePkg::*;

  localparam int divWidth = $clog2(`TICK_CYCLES + 1);
  localparam logic [divWidth-1:0] divLast = divWidth'(`TICK_CYCLES - 1);

  logic [divWidth-1:0] divCount;  // Position inside the current game second
  logic                lastTick;  // Tick that closes a timed phase

  assign tick     = (divCount == divLast);
  assign lastTick = tick && (countDownTime == ticks_t'(1));

  always_ff @(posedge Clk1Hz or posedge postPeriod) begin
    if (postPeriod) begin
      divCount <= '0;
    end else if ((phase == phaseIdle && start) || tick) begin
      divCount <= '0;  // Start realigns the seconds
    end else begin
      divCount <= divCount + 1'b1;
    end
  end

  always_ff @(posedge Clk1Hz or posedge postPeriod) begin
    if (postPeriod) begin
      phase         <= phaseIdle;
      countDownTime <= '0;
      reviewPage    <= '0;
      level         <= '0;
    end else begin
      // Remaining seconds of the phase, cases below reload it
      if (tick && countDownTime != '0) countDownTime <= countDownTime - 1'b1;
      case (phase)
        phaseIdle: begin
          if (start) begin
            phase         <= phasePrelim;
            countDownTime <= ticks_t'(`PRELIM_TICKS);
          end
        end
        phasePrelim: begin
          if (lastTick) begin
            phase         <= phasePlay;
            countDownTime <= ticks_t'(`GAME_SYMBOLS);
          end
        end
        phasePlay: begin
          if (lastTick) begin
            phase         <= phaseAnswer;
            countDownTime <= ticks_t'(`ANSWER_TICKS);
          end
        end
        phaseAnswer: begin
          if (lastTick) begin
            phase      <= phaseReview;
            reviewPage <= '0;
          end
        end
        phaseReview: begin
          if (tick) begin
            if (reviewPage != 2'd3) begin
              reviewPage <= reviewPage + 1'b1;  // One page per second
            end else if (!lose) begin
              phase         <= phasePrelim;     // Won, next level
              countDownTime <= ticks_t'(`PRELIM_TICKS);
              if (level != '1) level <= level + 1'b1;
            end
          end
        end
        default: phase <= phaseIdle;
      endcase
    end
  end

  // A lost round parks on the LOSE page until reset
  loseHoldsReview: assert property (@(posedge Clk1Hz) disable iff (postPeriod)
    (phase == phaseReview && reviewPage == 2'd3 && lose)
      |=> (phase == phaseReview && reviewPage == 2'd3));

endmodule

//--- source/symbolSource.sv
`timescale 1ns/10ps
`include "symbolGame_cfg.svh"

module symbolSource (
  input  logic                       Clk1Hz,
  input  logic                       postPeriod,
  input  symbolGamePkg::gamePhase_t  phase,
  input  logic                       tick,
  input  symbolGamePkg::level_t      level,
  output symbolGamePkg::symbol_t     generatedSymbol,
  output logic                       symbolStrobe,
  output symbolGamePkg::count_t      gameCount
);
  import symbolGamePkg::*;

  logic [7:0] lfsr;
  logic [7:0] lfsrNext;
  count_t     emitted;   // Symbols issued this round
  logic       emitNow;

  // Galois step, taps 0xB8, shifting right
  assign lfsrNext = (lfsr >> 1) ^ (lfsr[0] ? 8'hB8 : 8'h00);

  // First symbol right at play entry, then one per second until all are out
  assign emitNow = (phase == phasePlay) &&
                   (emitted == '0 || (tick && emitted < count_t'(`GAME_SYMBOLS)));

  always_ff @(posedge Clk1Hz or posedge postPeriod) begin
    if (postPeriod) begin
      lfsr            <= `SYMBOL_SEED;
      emitted         <= '0;
      generatedSymbol <= '0;
      symbolStrobe    <= 1'b0;
      gameCount       <= '0;
    end else begin
      symbolStrobe <= emitNow;
      if (phase == phasePrelim) begin
        lfsr      <= `SYMBOL_SEED ^ {3'b000, level};  // Held at seed for all of prelim
        emitted   <= '0;
        gameCount <= '0;
      end else if (emitNow) begin
        lfsr            <= lfsrNext;
        emitted         <= emitted + 1'b1;
        generatedSymbol <= lfsrNext[1:0];
        if (lfsrNext[1:0] == '0 && gameCount < count_t'(99))
          gameCount <= gameCount + 1'b1;  // Target seen
      end
    end
  end

endmodule

//--- source/scoreKeeper.sv
`timescale 1ns/10ps
`include "symbolGame_cfg.svh"

module scoreKeeper (
  input  logic                       Clk1Hz,
  input  logic                       postPeriod,
  input  symbolGamePkg::gamePhase_t  phase,
  input  logic                       press,
  input  symbolGamePkg::count_t      gameCount,
  output symbolGamePkg::count_t      userCount,
  output symbolGamePkg::count_t      countDifference,
  output logic                       lose
);
  import symbolGamePkg::*;

  count_t userNext;  // Count including this cycle's press
  count_t diffNext;

  always_comb begin
    userNext = userCount;
    if (phase == phaseAnswer && press && userCount < count_t'(99))
      userNext = userCount + 1'b1;
    diffNext = (userNext > gameCount) ? userNext - gameCount : gameCount - userNext;
  end

  // Verdict tracks every answer cycle so it is final on the first review cycle
  always_ff @(posedge Clk1Hz or posedge postPeriod) begin
    if (postPeriod) begin
      userCount       <= '0;
      countDifference <= '0;
      lose            <= 1'b0;
    end else if (phase == phasePrelim) begin
      userCount       <= '0;
      countDifference <= '0;
      lose            <= 1'b0;
    end else if (phase == phaseAnswer) begin
      userCount       <= userNext;
      countDifference <= diffNext;
      lose            <= (diffNext > count_t'(`LOSE_MARGIN));
    end
  end

  userCountLimit: assert property (@(posedge Clk1Hz) disable iff (postPeriod)
    userCount <= count_t'(99));

endmodule

//--- display/segmentDisplay.sv
`timescale 1ns/10ps

module segmentDisplay (
  input  logic                       Clk1Hz,
  input  logic                       postPeriod,
  input  symbolGamePkg::gamePhase_t  phase,
  input  logic [1:0]                 reviewPage,
  input  symbolGamePkg::ticks_t      countDownTime,
  input  symbolGamePkg::symbol_t     generatedSymbol,
  input  logic                       symbolStrobe,
  input  symbolGamePkg::count_t      userCount,
  input  symbolGamePkg::count_t      gameCount,
  input  symbolGamePkg::count_t      countDifference,
  input  logic                       lose,
  output symbolGamePkg::segPattern_t dig0,
  output symbolGamePkg::segPattern_t dig1,
  output symbolGamePkg::segPattern_t dig2,
  output symbolGamePkg::segPattern_t dig3
);
  import symbolGamePkg::*;

  gamePhase_t lastPhase;  // Spots the first play cycle

  function automatic segPattern_t tensSeg(input count_t value);
    return digitToSeg(4'(value / 7'd10));
  endfunction

  function automatic segPattern_t onesSeg(input count_t value);
    return digitToSeg(4'(value % 7'd10));
  endfunction

  always_ff @(posedge Clk1Hz or posedge postPeriod) begin
    if (postPeriod) begin
      lastPhase <= phaseIdle;
      dig0      <= digitToSeg(4'd0);
      dig1      <= segBlank;
      dig2      <= segBlank;
      dig3      <= segBlank;
    end else begin
      lastPhase <= phase;
      case (phase)
        phasePrelim: begin
          dig0 <= segLetterL;
          dig1 <= digitToSeg(countDownTime);  // Seconds left
          dig2 <= segBlank;
          dig3 <= segBlank;
        end
        phasePlay: begin
          if (lastPhase != phasePlay) begin
            dig0 <= segBlank;  // Fresh strip each round
            dig1 <= segBlank;
            dig2 <= segBlank;
            dig3 <= segBlank;
          end else if (symbolStrobe) begin
            // Newest symbol enters on the left
            dig3 <= dig2;
            dig2 <= dig1;
            dig1 <= dig0;
            dig0 <= symbolToSeg(generatedSymbol);
          end
        end
        phaseAnswer: begin
          dig0 <= segDash;
          dig1 <= segDash;
          dig2 <= segDash;
          dig3 <= segDash;
        end
        phaseReview: begin
          case (reviewPage)
            2'd0: begin
              dig0 <= segLetterP;  // Player count
              dig1 <= segBlank;
              dig2 <= tensSeg(userCount);
              dig3 <= onesSeg(userCount);
            end
            2'd1: begin
              dig0 <= segLetterS;  // True symbol count
              dig1 <= segBlank;
              dig2 <= tensSeg(gameCount);
              dig3 <= onesSeg(gameCount);
            end
            2'd2: begin
              dig0 <= segLetterD;
              dig1 <= segBlank;
              dig2 <= tensSeg(countDifference);
              dig3 <= onesSeg(countDifference);
            end
            default: begin
              dig0 <= lose ? segLetterL : segUnderscore;
              dig1 <= lose ? segLetterO : segUnderscore;
              dig2 <= lose ? segLetterS : segUnderscore;
              dig3 <= lose ? segLetterE : segUnderscore;
            end
          endcase
        end
        default: begin
          // Idle keeps whatever is showing
        end
      endcase
    end
  end

endmodule

//--- display/digitScanner.sv
`timescale 1ns/10ps

module digitScanner (
  input  logic                       Clk1Hz,
  input  logic                       postPeriod,
  input  symbolGamePkg::segPattern_t dig0,
  input  symbolGamePkg::segPattern_t dig1,
  input  symbolGamePkg::segPattern_t dig2,
  input  symbolGamePkg::segPattern_t dig3,
  output symbolGamePkg::segPattern_t seg,
  output logic [3:0]                 an
);
  import symbolGamePkg::*;

  logic [1:0] scanIndex;  // Digit driven next

  // Anode and segments land together so no ghosting between digits
  always_ff @(posedge Clk1Hz or posedge postPeriod) begin
    if (postPeriod) begin
      scanIndex <= '0;
      an        <= 4'b1111;  // All digits dark
      seg       <= segBlank;
    end else begin
      scanIndex <= scanIndex + 1'b1;  // Wraps after digit 3
      case (scanIndex)
        2'd0: begin an <= 4'b0111; seg <= dig0; end
        2'd1: begin an <= 4'b1011; seg <= dig1; end
        2'd2: begin an <= 4'b1101; seg <= dig2; end
        default: begin an <= 4'b1110; seg <= dig3; end
      endcase
    end
  end

  // Once lit, exactly one digit stays active every cycle
  oneDigitLit: assert property (@(posedge Clk1Hz) disable iff (postPeriod)
    (an != 4'b1111) |=> $onehot(~an));

endmodule

//--- source/symbolGameTop.sv
`timescale 1ns/10ps

module symbolGameTop (
  input  logic                       Clk1Hz,
  input  logic                       postPeriod,
  input  logic                       start,
  input  logic                       press,
  output symbolGamePkg::segPattern_t seg,
  output logic [3:0]                 an,
  output symbolGamePkg::gamePhase_t  phase,
  output symbolGamePkg::level_t      level,
  output logic                       lose
);
  import symbolGamePkg::*;

  logic        tick;             // One clock per game second
  ticks_t      countDownTime;
  logic [1:0]  reviewPage;
  symbol_t     generatedSymbol;
  logic        symbolStrobe;
  count_t      gameCount;
  count_t      userCount;
  count_t      countDifference;
  segPattern_t dig0;
  segPattern_t dig1;
  segPattern_t dig2;
  segPattern_t dig3;

  phaseController phaseCtrl (
    .Clk1Hz(Clk1Hz), .postPeriod(postPeriod), .start(start), .lose(lose),
    .phase(phase), .tick(tick), .countDownTime(countDownTime),
    .reviewPage(reviewPage), .level(level)
  );

  symbolSource symbolSrc (
    .Clk1Hz(Clk1Hz), .postPeriod(postPeriod), .phase(phase), .tick(tick),
    .level(level), .generatedSymbol(generatedSymbol), .symbolStrobe(symbolStrobe),
    .gameCount(gameCount)
  );

  scoreKeeper scoreKeep (
    .Clk1Hz(Clk1Hz), .postPeriod(postPeriod), .phase(phase), .press(press),
    .gameCount(gameCount), .userCount(userCount),
    .countDifference(countDifference), .lose(lose)
  );

  segmentDisplay display (
    .Clk1Hz(Clk1Hz), .postPeriod(postPeriod), .phase(phase), .reviewPage(reviewPage),
    .countDownTime(countDownTime), .generatedSymbol(generatedSymbol),
    .symbolStrobe(symbolStrobe), .userCount(userCount), .gameCount(gameCount),
    .countDifference(countDifference), .lose(lose),
    .dig0(dig0), .dig1(dig1), .dig2(dig2), .dig3(dig3)
  );

  digitScanner scanner (
    .Clk1Hz(Clk1Hz), .postPeriod(postPeriod),
    .dig0(dig0), .dig1(dig1), .dig2(dig2), .dig3(dig3),
    .seg(seg), .an(an)
  );

endmodule

//--- testbench/symbolGameTb.sv
`timescale 1ns/10ps
`include "symbolGame_cfg.svh"

module symbolGameTb;
  import symbolGamePkg::*;

  localparam int roundTicks    = `PRELIM_TICKS + `GAME_SYMBOLS + `ANSWER_TICKS + 4;
  localparam int loseHoldTicks = 2;  // Extra review windows parked on LOSE
  localparam int cycleLimit    = 2 * (2 * roundTicks + loseHoldTicks) * `TICK_CYCLES;

  logic        Clk1Hz;
  logic        postPeriod;
  logic        start;
  logic        press;
  segPattern_t seg;
  logic [3:0]  an;
  gamePhase_t  phase;
  level_t      level;
  logic        lose;

  int          errorCount = 0;
  int          testCount = 0;
  int          failedTests = 0;
  int          cycleCount = 0;
  logic [15:0] lfsrState = 16'd79;  // Press pattern source
  count_t      userPresses;         // Presses driven inside answer

  symbolGameTop dut (
    .Clk1Hz(Clk1Hz), .postPeriod(postPeriod), .start(start), .press(press),
    .seg(seg), .an(an), .phase(phase), .level(level), .lose(lose)
  );

  initial begin
    Clk1Hz = 1'b0;
    forever #50 Clk1Hz = ~Clk1Hz;  // 100 ns period
  end

  always @(posedge Clk1Hz) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      $display("run stopped at cycle %0d before the tests finished", cycleCount);
      $display("Verification failed");
      $finish;
    end
  end

  // Galois step with taps 0xB400 for each bit used
  function automatic logic lfsrBit();
    lfsrState = (lfsrState >> 1) ^ (lfsrState[0] ? 16'hB400 : 16'h0000);
    return lfsrState[0];
  endfunction

  function automatic logic [`TICK_CYCLES-1:0] pressPattern();
    logic [`TICK_CYCLES-1:0] mask;
    int                      i;
    for (i = 0; i < `TICK_CYCLES; i++) mask[i] = lfsrBit();
    return mask;
  endfunction

  // Symbol number index of a round seeded with base seed xor level
  function automatic symbol_t symbolAt(input level_t lvl, input int index);
    logic [7:0] state;
    int         i;
    state = 8'(`SYMBOL_SEED) ^ {3'b000, lvl};
    for (i = 0; i <= index; i++) state = (state >> 1) ^ (state[0] ? 8'hB8 : 8'h00);
    return state[1:0];
  endfunction

  function automatic count_t targetCount(input level_t lvl);
    count_t n;
    int     i;
    n = '0;
    for (i = 0; i < `GAME_SYMBOLS; i++) begin
      if (symbolAt(lvl, i) == 2'd0 && n < count_t'(99)) n = n + 1'b1;
    end
    return n;
  endfunction

  function automatic count_t countGap(input level_t lvl, input count_t userCnt);
    count_t gameCnt;
    gameCnt = targetCount(lvl);
    if (userCnt > gameCnt) return userCnt - gameCnt;
    return gameCnt - userCnt;
  endfunction

  function automatic logic roundLost(input level_t lvl, input count_t userCnt);
    return countGap(lvl, userCnt) > count_t'(`LOSE_MARGIN);
  endfunction

  // Expected digit pos during one tick window of a phase
  function automatic segPattern_t expectedDigit(input gamePhase_t ph, input int window,
                                                input int pos, input level_t lvl,
                                                input count_t userCnt);
    count_t shown;
    int     page;
    int     symIndex;
    symIndex = window - pos;  // Older symbols sit further right
    page     = (window > 3) ? 3 : window;
    case (ph)
      phasePrelim: begin
        if (pos == 0) return segLetterL;
        if (pos == 1) return digitToSeg(4'(`PRELIM_TICKS - window));  // Seconds left
        return segBlank;
      end
      phasePlay: begin
        if (symIndex < 0) return segBlank;
        return symbolToSeg(symbolAt(lvl, symIndex));
      end
      phaseAnswer: return segDash;
      phaseReview: begin
        if (page == 3 && roundLost(lvl, userCnt)) begin
          case (pos)
            0: return segLetterL;
            1: return segLetterO;
            2: return segLetterS;
            default: return segLetterE;
          endcase
        end
        if (page == 3) return segUnderscore;
        case (page)
          0: shown = userCnt;
          1: shown = targetCount(lvl);
          default: shown = countGap(lvl, userCnt);
        endcase
        if (pos == 0) return (page == 0) ? segLetterP : (page == 1) ? segLetterS : segLetterD;
        if (pos == 1) return segBlank;
        if (pos == 2) return digitToSeg(4'(shown / 7'd10));
        return digitToSeg(4'(shown % 7'd10));
      end
      default: return (pos == 0) ? digitToSeg(4'd0) : segBlank;  // Idle after reset
    endcase
  endfunction

  function automatic int anodeIndex(input logic [3:0] anodes);
    case (anodes)
      4'b0111: return 0;
      4'b1011: return 1;
      4'b1101: return 2;
      4'b1110: return 3;
      default: return -1;
    endcase
  endfunction

  task automatic checkDigit(input string name, input segPattern_t expected,
                            input segPattern_t actual);
    if (actual !== expected) begin
      $display("mismatch %s expected %h actual %h", name, expected, actual);
      errorCount++;
    end
  endtask

  task automatic checkPhase(input string name, input gamePhase_t expected,
                            input gamePhase_t actual);
    if (actual !== expected) begin
      $display("mismatch %s phase expected %s actual %s", name, expected.name(), actual.name());
      errorCount++;
    end
  endtask

  task automatic checkLevel(input string name, input level_t expected, input level_t actual);
    if (actual !== expected) begin
      $display("mismatch %s level expected %0d actual %0d", name, expected, actual);
      errorCount++;
    end
  endtask

  task automatic checkLose(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("mismatch %s lose expected %b actual %b", name, expected, actual);
      errorCount++;
    end
  endtask

  task automatic checkAnodes(input string name, input logic [3:0] expected,
                             input logic [3:0] actual);
    if (actual !== expected) begin
      $display("mismatch %s an expected %b actual %b", name, expected, actual);
      errorCount++;
    end
  endtask

  task automatic reportTest(input string name, input int errorsBefore);
    testCount++;
    if (errorCount == errorsBefore) begin
      $display("ok      %s", name);
    end else begin
      failedTests++;
      $display("failed  %s", name);
    end
  endtask

  // One tick window from just after its first rising edge
  task automatic runWindow(input gamePhase_t expPhase, input int window, input level_t lvl,
                           input logic [`TICK_CYCLES-1:0] pressMask);
    string                   name;
    segPattern_t             seen [4];
    logic [3:0]              lit;
    logic [`TICK_CYCLES-1:0] pending;
    logic                    expLose;
    int                      errorsBefore;
    int                      c;
    int                      d;
    name         = $sformatf("level %0d %s window %0d", lvl, expPhase.name(), window);
    errorsBefore = errorCount;
    lit          = '0;
    pending      = pressMask;
    press <= pending[0];
    for (c = 0; c < `TICK_CYCLES; c++) begin
      @(negedge Clk1Hz);
      if (expPhase == phaseAnswer && press && userPresses < count_t'(99))
        userPresses = userPresses + 1'b1;
      if (c >= `TICK_CYCLES - 4) begin  // Digits and scan settled
        d = anodeIndex(an);
        if (d < 0) begin
          $display("%s scan drove anodes %b instead of one lit digit", name, an);
          errorCount++;
        end else begin
          seen[d] = seg;
          lit[d]  = 1'b1;
        end
      end
      if (c == `TICK_CYCLES - 1) begin
        expLose = (expPhase == phaseReview) ? roundLost(lvl, userPresses) : 1'b0;
        checkPhase(name, expPhase, phase);
        checkLevel(name, lvl, level);
        if (expPhase != phaseAnswer) checkLose(name, expLose, lose);  // Settling in answer
      end
      @(posedge Clk1Hz);
      pending = pending >> 1;
      press <= pending[0];
    end
    for (d = 0; d < 4; d++) begin
      if (!lit[d]) begin
        $display("%s digit %0d was never scanned", name, d);
        errorCount++;
      end else begin
        checkDigit($sformatf("%s dig%0d", name, d),
                   expectedDigit(expPhase, window, d, lvl, userPresses), seen[d]);
      end
    end
    reportTest(name, errorsBefore);
  endtask

  task automatic playRound(input level_t lvl, input logic wantWin);
    logic [`TICK_CYCLES-1:0] mask;
    int                      offset;
    int                      wanted;  // Presses inside answer
    int                      placed;
    int                      w;
    int                      s;
    offset = 0;
    for (s = 0; s < 2; s++) offset = offset * 2 + int'(lfsrBit());
    if (wantWin) offset = offset % 3 - 1;       // Off by at most one
    else offset = offset + `LOSE_MARGIN + 1;    // Too far off
    wanted = int'(targetCount(lvl)) + offset;
    if (wanted < 0) wanted = 0;
    userPresses = '0;
    for (w = 0; w < `PRELIM_TICKS; w++) runWindow(phasePrelim, w, lvl, pressPattern());
    for (w = 0; w < `GAME_SYMBOLS; w++) runWindow(phasePlay, w, lvl, pressPattern());
    placed = 0;
    for (w = 0; w < `ANSWER_TICKS; w++) begin
      mask = '0;
      for (s = 0; s < `TICK_CYCLES; s += 2) begin
        if (placed < wanted) begin  // Pulse on every other clock
          mask[s] = 1'b1;
          placed++;
        end
      end
      runWindow(phaseAnswer, w, lvl, mask);
    end
    for (w = 0; w < 4; w++) runWindow(phaseReview, w, lvl, pressPattern());
    if (!wantWin) begin
      for (w = 4; w < 4 + loseHoldTicks; w++) begin
        runWindow(phaseReview, w, lvl, pressPattern());  // Parked on LOSE
      end
    end
  endtask

  initial begin
    int k;
    int errorsBefore;
    postPeriod   = 1'b1;
    start        = 1'b0;
    press        = 1'b0;
    userPresses  = '0;
    errorsBefore = errorCount;
    repeat (2) @(posedge Clk1Hz);
    @(negedge Clk1Hz);
    checkAnodes("reset", 4'b1111, an);
    checkDigit("reset seg", segBlank, seg);
    checkPhase("reset", phaseIdle, phase);
    checkLose("reset", 1'b0, lose);
    @(posedge Clk1Hz);
    postPeriod <= 1'b0;  // Third edge ends reset
    for (k = 0; k < 8; k++) begin
      @(posedge Clk1Hz);
      @(negedge Clk1Hz);
      checkAnodes("idle scan", 4'b1111 ^ (4'b1000 >> (k % 4)), an);
      checkDigit($sformatf("idle scan dig%0d", k % 4),
                 (k % 4 == 0) ? digitToSeg(4'd0) : segBlank, seg);
      checkPhase("idle scan", phaseIdle, phase);
      checkLose("idle scan", 1'b0, lose);
    end
    reportTest("reset and idle scan", errorsBefore);

    @(posedge Clk1Hz);
    start <= 1'b1;
    @(posedge Clk1Hz);
    start <= 1'b0;
    playRound(5'd0, 1'b1);  // Win leads straight into the next level
    playRound(5'd1, 1'b0);  // Loss parks in review

    errorsBefore = errorCount;
    postPeriod <= 1'b1;
    repeat (2) @(posedge Clk1Hz);
    @(negedge Clk1Hz);
    checkPhase("reset after loss", phaseIdle, phase);
    checkLevel("reset after loss", 5'd0, level);
    checkLose("reset after loss", 1'b0, lose);
    checkAnodes("reset after loss", 4'b1111, an);
    checkDigit("reset after loss seg", segBlank, seg);
    @(posedge Clk1Hz);
    postPeriod <= 1'b0;
    reportTest("reset after lost round", errorsBefore);

    $display("%0d tests, %0d failed, %0d errors", testCount, failedTests, errorCount);
    if (errorCount == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- filelist.f
+incdir+common
common/symbolGamePkg.sv
source/phaseController.sv
source/symbolSource.sv
source/scoreKeeper.sv
display/segmentDisplay.sv
display/digitScanner.sv
source/symbolGameTop.sv
testbench/symbolGameTb.sv

//--- Makefile
VERILATOR  = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP        = symbolGameTb
FILELIST   = filelist.f
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "Verification passed" $(LOG); then echo "simulation did not complete"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
